//--- rtl/lsu_consts.svh
//////////////////////////////////////////////////////////////////////
// Width and access size constants for the load/store unit
// Included by the package and by every RTL module that sizes ports
//////////////////////////////////////////////////////////////////////

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data path widths
`define LSU_WORD_W      32          // Data and address width
`define LSU_SEL_W       4           // Byte selects per word
`define LSU_HALF_W      16          // Halfword lane width
`define LSU_BYTE_W      8           // Byte lane width

// Access size codes, as decoded in the X stage
`define LSU_SIZE_W      2
`define LSU_SIZE_BYTE   2'b00
`define LSU_SIZE_HWORD  2'b11
`define LSU_SIZE_WORD   2'b10       // Code 01 never issued

`endif

//--- rtl/lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the load/store unit
// Imported by the RTL modules and by the testbench model
//////////////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

package lsu_pkg;

    // One data word, seen as byte lanes or as halfword lanes
    // Lane 3 and halfword 1 are the most significant
    // Big-endian, so address bits 00 name lane 3
    typedef union packed
    {
        logic [`LSU_SEL_W-1:0][`LSU_BYTE_W-1:0] b;    // Byte lanes
        logic [1:0][`LSU_HALF_W-1:0]            h;    // Halfword lanes
    } lsu_lane_u;

    // Access as held in the M stage
    typedef struct packed
    {
        logic [`LSU_SIZE_W-1:0] size;         // Byte, halfword or word
        logic                   sign_ext;     // Sign-extend on load
        logic [`LSU_SEL_W-1:0]  sel;          // Big-endian byte enables
        lsu_lane_u              store_data;   // Operand in every lane
    } lsu_mreq_t;

    // Registered Wishbone master outputs
    // Stb follows cyc, so it has no field of its own
    typedef struct packed
    {
        logic [`LSU_WORD_W-1:0] adr;
        logic [`LSU_WORD_W-1:0] dat;
        logic [`LSU_SEL_W-1:0]  sel;
        logic                   cyc;
        logic                   we;
    } wb_req_t;

endpackage

//--- rtl/lsu_store_format.sv
//////////////////////////////////////////////////////////////////////
// X stage of the load/store unit: byte enables, store lane copies
// and the X/M stage register, frozen while the M stage stalls
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_store_format
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   stall_m_i,           // Holds the X/M register
    input  logic [`LSU_SIZE_W-1:0] size_x_i,            // Access size in X
    input  logic                   sign_ext_x_i,        // Load sign extension
    input  logic [1:0]             addr_lsb_x_i,        // Byte offset in word
    input  logic [`LSU_WORD_W-1:0] store_operand_x_i,   // Register operand
    output lsu_mreq_t              mreq_o               // M stage access
);

    logic [`LSU_SEL_W-1:0] sel_x;     // Byte enables for this access
    lsu_lane_u             lanes_x;   // Operand copied into lanes

    //////////////////////////////////////////////////////////////////////
    // Byte enables, most significant lane at offset 00
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        casez ({size_x_i, addr_lsb_x_i})
            {`LSU_SIZE_BYTE, 2'b00}:  sel_x = 4'b1000;
            {`LSU_SIZE_BYTE, 2'b01}:  sel_x = 4'b0100;
            {`LSU_SIZE_BYTE, 2'b10}:  sel_x = 4'b0010;
            {`LSU_SIZE_BYTE, 2'b11}:  sel_x = 4'b0001;
            {`LSU_SIZE_HWORD, 2'b0?}: sel_x = 4'b1100;   // Upper halfword
            {`LSU_SIZE_HWORD, 2'b1?}: sel_x = 4'b0011;   // Lower halfword
            {`LSU_SIZE_WORD, 2'b??}:  sel_x = 4'b1111;
            default:                  sel_x = 4'b0000;   // Unused size code
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Store data replication
    //////////////////////////////////////////////////////////////////////
    // Every lane carries the operand, the selects pick the live one
    always_comb
    begin
        case (size_x_i)
            `LSU_SIZE_BYTE:
                lanes_x.b = {`LSU_SEL_W{store_operand_x_i[`LSU_BYTE_W-1:0]}};
            `LSU_SIZE_HWORD:
                lanes_x.h = {2{store_operand_x_i[`LSU_HALF_W-1:0]}};
            `LSU_SIZE_WORD:
                lanes_x = store_operand_x_i;               // Already in place
            default:
                lanes_x = '0;
        endcase
    end

    // X/M stage register
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            mreq_o <= '0;
        end
        else if (!stall_m_i)                    // Advance only when M moves
        begin
            mreq_o.size       <= size_x_i;
            mreq_o.sign_ext   <= sign_ext_x_i;
            mreq_o.sel        <= sel_x;
            mreq_o.store_data <= lanes_x;
        end
    end

endmodule

//--- rtl/lsu_bus_master.sv
//////////////////////////////////////////////////////////////////////
// Single-access Wishbone master of the load/store unit
// Issues store writes and load reads, owns the load stall
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_bus_master
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   stall_x_i,
    input  logic                   stall_m_i,
    input  logic                   kill_m_i,         // Cancels a pending load
    input  logic                   exception_m_i,    // Same effect as kill
    input  logic                   load_q_x_i,       // Load in X
    input  logic                   load_q_m_i,       // Load in M
    input  logic                   store_q_m_i,      // Store in M
    input  logic [`LSU_WORD_W-1:0] addr_m_i,
    input  lsu_mreq_t              mreq_i,           // From the X/M register
    input  logic [`LSU_WORD_W-1:0] d_dat_i,
    input  logic                   d_ack_i,
    input  logic                   d_err_i,
    output wb_req_t                wb_o,             // Registered bus outputs
    output logic [`LSU_WORD_W-1:0] rd_data_o,        // Last word read
    output logic                   stall_wb_load_o   // Hold pipeline for load
);

    logic bus_idle;     // No cycle in progress
    logic cyc_end;      // Slave ends the cycle this clock
    logic start_wr;     // Store leaves M
    logic start_rd;     // Pending load gets the bus
    logic load_done;    // Read word for the load in M is captured

    assign bus_idle = !wb_o.cyc;
    assign cyc_end  = wb_o.cyc && (d_ack_i || d_err_i);   // Err ends like ack
    assign start_wr = bus_idle && store_q_m_i && !stall_m_i;
    assign start_rd = bus_idle && !start_wr && load_q_m_i && !load_done;

    //////////////////////////////////////////////////////////////////////
    // Bus cycle
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wb_o <= '0;
        end
        else if (cyc_end)
        begin
            wb_o.cyc <= 1'b0;                   // Drop one edge after ack
            wb_o.we  <= 1'b0;
        end
        else if (start_wr || start_rd)
        begin
            wb_o.adr <= addr_m_i;
            wb_o.sel <= mreq_i.sel;
            wb_o.cyc <= 1'b1;
            wb_o.we  <= start_wr;
            if (start_wr)
                wb_o.dat <= mreq_i.store_data;  // Lanes already replicated
        end
    end

    // Read word and load-complete flag
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rd_data_o <= '0;
            load_done <= 1'b0;
        end
        else
        begin
            if (cyc_end)
                rd_data_o <= d_dat_i;           // Taken on err as well
            if (!stall_m_i)
                load_done <= 1'b0;              // Load has left M
            else if (cyc_end && !wb_o.we)
                load_done <= 1'b1;              // Stores never set it
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Load stall
    //////////////////////////////////////////////////////////////////////
    // Raised as a load enters M, dropped once its read starts
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            stall_wb_load_o <= 1'b0;
        else if (kill_m_i || exception_m_i)     // Cancelled load wins
            stall_wb_load_o <= 1'b0;
        else if (load_q_x_i && !stall_x_i)
            stall_wb_load_o <= 1'b1;
        else if (start_rd)
            stall_wb_load_o <= 1'b0;            // Cyc keeps the pipe stalled
    end

endmodule

//--- rtl/lsu_load_align.sv
//////////////////////////////////////////////////////////////////////
// W stage of the load/store unit: M/W register, lane selection
// and sign or zero extension of the loaded field
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`LSU_WORD_W-1:0] rd_data_i,      // Captured bus word
    input  logic [`LSU_SIZE_W-1:0] size_m_i,
    input  logic                   sign_ext_m_i,
    input  logic [1:0]             addr_lsb_m_i,   // Byte offset in M
    output logic [`LSU_WORD_W-1:0] load_data_w_o   // Aligned load result
);

    lsu_lane_u              data_w;      // Word in W, seen as lanes
    logic [`LSU_SIZE_W-1:0] size_w;
    logic                   sign_ext_w;
    logic [1:0]             addr_lsb_w;
    logic [`LSU_BYTE_W-1:0] byte_w;      // Addressed byte
    logic [`LSU_HALF_W-1:0] half_w;      // Addressed halfword

    // M/W stage register, no stall in this stage
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            data_w     <= '0;
            size_w     <= '0;
            sign_ext_w <= 1'b0;
            addr_lsb_w <= '0;
        end
        else
        begin
            data_w     <= rd_data_i;
            size_w     <= size_m_i;
            sign_ext_w <= sign_ext_m_i;
            addr_lsb_w <= addr_lsb_m_i;
        end
    end

    // Big-endian lanes, so offset 00 reads lane 3
    assign byte_w = data_w.b[~addr_lsb_w];
    assign half_w = data_w.h[~addr_lsb_w[1]];

    //////////////////////////////////////////////////////////////////////
    // Extension
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (size_w)
            `LSU_SIZE_BYTE:
                load_data_w_o = {{(`LSU_WORD_W-`LSU_BYTE_W){sign_ext_w & byte_w[7]}}, byte_w};
            `LSU_SIZE_HWORD:
                load_data_w_o = {{(`LSU_WORD_W-`LSU_HALF_W){sign_ext_w & half_w[15]}}, half_w};
            `LSU_SIZE_WORD:
                load_data_w_o = data_w;            // Whole word unchanged
            default:
                load_data_w_o = '0;
        endcase
    end

endmodule

//--- rtl/lsu_top.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit top level, X to W stages on a Wishbone data bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Pipeline control
    input  logic                   stall_x_i,
    input  logic                   stall_m_i,
    input  logic                   kill_m_i,
    input  logic                   exception_m_i,
    input  logic                   load_q_x_i,
    input  logic                   load_q_m_i,
    input  logic                   store_q_m_i,
    // Access in X and M
    input  logic [`LSU_WORD_W-1:0] store_operand_x_i,
    input  logic [`LSU_WORD_W-1:0] addr_x_i,
    input  logic [`LSU_WORD_W-1:0] addr_m_i,
    input  logic [`LSU_SIZE_W-1:0] size_x_i,
    input  logic                   sign_ext_x_i,
    // To pipeline
    output logic [`LSU_WORD_W-1:0] load_data_w_o,
    output logic                   stall_wb_load_o,
    // Wishbone data bus
    input  logic [`LSU_WORD_W-1:0] d_dat_i,
    input  logic                   d_ack_i,
    input  logic                   d_err_i,
    output logic [`LSU_WORD_W-1:0] d_dat_o,
    output logic [`LSU_WORD_W-1:0] d_adr_o,
    output logic [`LSU_SEL_W-1:0]  d_sel_o,
    output logic                   d_cyc_o,
    output logic                   d_stb_o,
    output logic                   d_we_o
);

    lsu_mreq_t              mreq_m;      // X/M register contents
    wb_req_t                wb_req;      // Bus master outputs
    logic [`LSU_WORD_W-1:0] rd_data_m;   // Word read from the bus

    lsu_store_format u_store_format (
        .clk_i, .rst_n_i, .stall_m_i, .size_x_i, .sign_ext_x_i,
        .addr_lsb_x_i      (addr_x_i[1:0]),      // Only the offset matters here
        .store_operand_x_i,
        .mreq_o            (mreq_m)
    );

    lsu_bus_master u_bus_master (
        .clk_i, .rst_n_i, .stall_x_i, .stall_m_i, .kill_m_i, .exception_m_i,
        .load_q_x_i, .load_q_m_i, .store_q_m_i, .addr_m_i,
        .mreq_i          (mreq_m),
        .d_dat_i, .d_ack_i, .d_err_i,
        .wb_o            (wb_req),
        .rd_data_o       (rd_data_m),
        .stall_wb_load_o
    );

    lsu_load_align u_load_align (
        .clk_i, .rst_n_i,
        .rd_data_i     (rd_data_m),
        .size_m_i      (mreq_m.size),
        .sign_ext_m_i  (mreq_m.sign_ext),
        .addr_lsb_m_i  (addr_m_i[1:0]),
        .load_data_w_o
    );

    // Wishbone port unpacking
    assign d_adr_o = wb_req.adr;
    assign d_dat_o = wb_req.dat;
    assign d_sel_o = wb_req.sel;
    assign d_cyc_o = wb_req.cyc;
    assign d_stb_o = wb_req.cyc;    // One strobe per cycle
    assign d_we_o  = wb_req.we;

endmodule

//--- test/lsu_chk.sv
//////////////////////////////////////////////////////////////////////
// Wishbone and load stall protocol checks, bound to the LSU top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_chk
(
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   cyc_i,
    input logic                   stb_i,
    input logic                   we_i,
    input logic [`LSU_WORD_W-1:0] adr_i,
    input logic [`LSU_WORD_W-1:0] dat_i,
    input logic [`LSU_SEL_W-1:0]  sel_i,
    input logic                   ack_i,
    input logic                   err_i,
    input logic                   stall_load_i
);

    int unsigned stb_fails  = 0;
    int unsigned hold_fails = 0;
    int unsigned end_fails  = 0;
    int unsigned rst_fails  = 0;
    int unsigned fail_cnt;                  // Read by the testbench at the end

    assign fail_cnt = stb_fails + hold_fails + end_fails + rst_fails;

    stb_is_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stb_i == cyc_i)
    else
    begin
        $error("Strobe differs from cycle");
        stb_fails++;
    end

    // Request fields frozen until the slave answers
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cyc_i && !ack_i && !err_i) |=>
            ($stable(adr_i) && $stable(sel_i) && $stable(dat_i) && $stable(we_i)))
    else
    begin
        $error("Bus request changed before ack or err");
        hold_fails++;
    end

    cyc_ends: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cyc_i && (ack_i || err_i)) |=> !cyc_i)
    else
    begin
        $error("Cycle still open one clock after ack or err");
        end_fails++;
    end

    rst_quiet: assert property (@(posedge clk_i) !rst_n_i |-> (!stall_load_i && !cyc_i))
    else
    begin
        $error("Load stall or cycle high in reset");
        rst_fails++;
    end

endmodule

bind lsu_top lsu_chk u_chk
(
    .clk_i,
    .rst_n_i,
    .cyc_i        (d_cyc_o),
    .stb_i        (d_stb_o),
    .we_i         (d_we_o),
    .adr_i        (d_adr_o),
    .dat_i        (d_dat_o),
    .sel_i        (d_sel_o),
    .ack_i        (d_ack_i),
    .err_i        (d_err_i),
    .stall_load_i (stall_wb_load_o)
);

//--- test/lsu_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the load/store unit: random pipeline accesses, a
// Wishbone slave with wait states and errors, and a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int SEED       = 71107;
    localparam int NUM_TESTS  = 60;
    localparam int MAX_WAIT   = 3;         // Slave wait states before ack
    localparam int PERIOD     = 40;
    localparam int RST_CYCLES = 16;
    localparam int DRV_DLY    = 2;         // Input skew after the edge
    localparam int CYC_LIMIT  = 8;         // Longest bus cycle tolerated

    logic        clk_i, rst_n_i;
    logic        stall_x_i, stall_m_i, kill_m_i, exception_m_i;
    logic        load_q_x_i, load_q_m_i, store_q_m_i;
    logic [31:0] store_operand_x_i, addr_x_i, addr_m_i;
    logic [1:0]  size_x_i;
    logic        sign_ext_x_i;
    logic [31:0] load_data_w_o;
    logic        stall_wb_load_o;
    logic [31:0] d_dat_i, d_dat_o, d_adr_o;
    logic        d_ack_i, d_err_i;
    logic [3:0]  d_sel_o;
    logic        d_cyc_o, d_stb_o, d_we_o;

    // Slave response for the access under test
    logic [31:0] rsp_word;
    logic        rsp_err;
    int unsigned rsp_waits;

    int unsigned errors, failed, errs_before, kind, rnd;
    logic [1:0]  size;
    logic [31:0] addr, operand;

    lsu_top lsu_top_i (.*);

    always #(PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [3:0] sel_for(input logic [1:0] sz, input logic [1:0] off);
        case (sz)
            `LSU_SIZE_BYTE:  return 4'b1000 >> off;       // Offset 0 is lane 3
            `LSU_SIZE_HWORD: return off[1] ? 4'b0011 : 4'b1100;
            default:         return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lanes_for(input logic [1:0] sz, input logic [31:0] op);
        case (sz)
            `LSU_SIZE_BYTE:  return {4{op[7:0]}};
            `LSU_SIZE_HWORD: return {2{op[15:0]}};
            default:         return op;
        endcase
    endfunction

    function automatic logic [31:0] load_result(input logic [1:0] sz, input logic sign,
                                                input logic [1:0] off, input logic [31:0] word);
        lsu_lane_u  w;
        logic [1:0] lane;
        w    = word;
        lane = 2'd3 - off;                             // Big-endian lane number
        case (sz)
            `LSU_SIZE_BYTE:  return {{24{sign & w.b[lane][7]}}, w.b[lane]};
            `LSU_SIZE_HWORD: return {{16{sign & w.h[!off[1]][15]}}, w.h[!off[1]]};
            default:         return word;
        endcase
    endfunction

    function automatic logic [1:0] size_code(input int unsigned r);
        case (r)
            0:       return `LSU_SIZE_BYTE;
            1:       return `LSU_SIZE_HWORD;
            default: return `LSU_SIZE_WORD;
        endcase
    endfunction

    function automatic string kind_name(input int unsigned k);
        case (k)
            0:       return "word store";
            1:       return "byte store";
            2:       return "halfword store";
            3:       return "store with err";
            4:       return "word load";
            5:       return "sub-word load";
            6:       return "load with err";
            7:       return "killed load";
            default: return "load with exception";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk_i);
        #DRV_DLY;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Pipeline stays stalled here until the slave closes the cycle
    task automatic wait_bus_end();
        int unsigned n;
        n = 0;
        while (d_cyc_o && n < CYC_LIMIT)
        begin
            next_cycle();
            n++;
        end
        assert (!d_cyc_o)
        else
        begin
            $display("Bus cycle still open after %0d clocks, no ack or err seen", CYC_LIMIT);
            errors++;
        end
    endtask

    task automatic store_access(input logic [1:0] sz, input logic [31:0] a,
                                input logic [31:0] op);
        size_x_i          = sz;                      // X stage
        addr_x_i          = a;
        store_operand_x_i = op;
        sign_ext_x_i      = 1'b0;
        next_cycle();
        store_q_m_i = 1'b1;                          // M stage, bus idle
        addr_m_i    = a;
        next_cycle();
        store_q_m_i = 1'b0;
        stall_x_i   = 1'b1;
        stall_m_i   = 1'b1;
        check_bit("d_cyc_o", d_cyc_o, 1'b1);
        check_bit("d_we_o", d_we_o, 1'b1);
        compare_word("d_adr_o", d_adr_o, a);
        compare_word("d_sel_o", {28'b0, d_sel_o}, {28'b0, sel_for(sz, a[1:0])});
        compare_word("d_dat_o", d_dat_o, lanes_for(sz, op));
        wait_bus_end();
        stall_x_i = 1'b0;
        stall_m_i = 1'b0;
    endtask

    // Cancel 1 is kill, 2 is exception, 0 lets the load run
    task automatic load_access(input logic [1:0] sz, input logic [31:0] a,
                               input logic sign, input logic [1:0] cancel);
        size_x_i     = sz;
        addr_x_i     = a;
        sign_ext_x_i = sign;
        load_q_x_i   = 1'b1;
        next_cycle();
        check_bit("stall_wb_load_o", stall_wb_load_o, 1'b1);
        load_q_x_i = 1'b0;
        stall_x_i  = 1'b1;
        stall_m_i  = 1'b1;
        addr_m_i   = a;
        if (cancel != 2'd0)
        begin
            kill_m_i      = (cancel == 2'd1);
            exception_m_i = (cancel == 2'd2);
            next_cycle();
            check_bit("stall_wb_load_o", stall_wb_load_o, 1'b0);
            check_bit("d_cyc_o", d_cyc_o, 1'b0);
            kill_m_i      = 1'b0;
            exception_m_i = 1'b0;
            stall_x_i     = 1'b0;
            stall_m_i     = 1'b0;
            repeat (3)
            begin
                next_cycle();
                check_bit("d_cyc_o", d_cyc_o, 1'b0);   // Cancelled load stays off the bus
            end
        end
        else
        begin
            load_q_m_i = 1'b1;
            next_cycle();
            check_bit("d_cyc_o", d_cyc_o, 1'b1);
            check_bit("d_we_o", d_we_o, 1'b0);
            check_bit("stall_wb_load_o", stall_wb_load_o, 1'b0);
            compare_word("d_adr_o", d_adr_o, a);
            compare_word("d_sel_o", {28'b0, d_sel_o}, {28'b0, sel_for(sz, a[1:0])});
            wait_bus_end();
            stall_x_i = 1'b0;                        // Load leaves M next edge
            stall_m_i = 1'b0;
            next_cycle();
            load_q_m_i = 1'b0;
            compare_word("load_data_w_o", load_data_w_o, load_result(sz, sign, a[1:0], rsp_word));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Wishbone slave
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        forever
        begin
            next_cycle();
            if (d_cyc_o)
            begin
                repeat (rsp_waits) next_cycle();
                d_dat_i = rsp_word;
                d_ack_i = !rsp_err;
                d_err_i = rsp_err;                   // Err ends the cycle like ack
                next_cycle();
                d_ack_i = 1'b0;
                d_err_i = 1'b0;
                d_dat_i = ~rsp_word;                 // Junk between cycles
            end
        end
    end

    // Watchdog, 16 clocks per test plus reset
    initial
    begin
        #((RST_CYCLES + NUM_TESTS * 16) * PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(SEED));
        errors = 0;
        failed = 0;
        clk_i = 1'b0;
        rst_n_i = 1'b1;
        {stall_x_i, stall_m_i, kill_m_i, exception_m_i} = '0;
        {load_q_x_i, load_q_m_i, store_q_m_i, sign_ext_x_i} = '0;
        {store_operand_x_i, addr_x_i, addr_m_i, size_x_i} = '0;
        {d_dat_i, d_ack_i, d_err_i} = '0;
        rsp_word  = '0;
        rsp_err   = 1'b0;
        rsp_waits = 0;
        #1 rst_n_i = 1'b0;                           // Edge for the async reset
        repeat (RST_CYCLES) @(posedge clk_i);
        #DRV_DLY;
        rst_n_i = 1'b1;
        check_bit("stall_wb_load_o", stall_wb_load_o, 1'b0);
        check_bit("d_cyc_o", d_cyc_o, 1'b0);
        next_cycle();
        for (int unsigned t = 0; t < NUM_TESTS; t++)
        begin
            kind = (t < 9) ? t : $urandom_range(0, 8);   // Each kind once, then random
            errs_before = errors;
            rnd = $urandom();
            case (kind)
                0, 4:    size = `LSU_SIZE_WORD;
                1:       size = `LSU_SIZE_BYTE;
                2:       size = `LSU_SIZE_HWORD;
                5:       size = size_code($urandom_range(0, 1));
                default: size = size_code($urandom_range(0, 2));
            endcase
            addr = $urandom();
            if (size == `LSU_SIZE_WORD)
                addr[1:0] = 2'b00;
            else if (size == `LSU_SIZE_HWORD)
                addr[0] = 1'b0;
            operand   = $urandom();
            rsp_word  = $urandom();
            rsp_waits = $urandom_range(0, MAX_WAIT);
            rsp_err   = (kind == 3) || (kind == 6);
            if (kind < 4)
                store_access(size, addr, operand);
            else
                load_access(size, addr, rnd[0], (kind == 7) ? 2'd1 : (kind == 8) ? 2'd2 : 2'd0);
            if (errors == errs_before)
            begin
                $display("test %0d %s ok", t, kind_name(kind));
            end
            else
            begin
                $display("test %0d %s failed", t, kind_name(kind));
                failed++;
            end
        end
        repeat (2) next_cycle();
        errors += lsu_top_i.u_chk.fail_cnt;          // Bound assertion failures
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_store_format.sv
rtl/lsu_bus_master.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
test/lsu_chk.sv
test/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

TOP = lsu_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		-f sim.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
